// File: build.f
design/num_pkg.sv
design/bus_pkg.sv
design/rst_stagger.sv
design/neuron_core.sv
design/out_collector.sv
design/multicore.sv
sim/tb_clock.sv
sim/tb_multicore.sv

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator, run, then look for the fail message in the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_multicore \
	-f build.f -o sim_multicore > build.log 2>&1 \
	&& ./obj_dir/sim_multicore > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// File: sim/tb_multicore.sv
`default_nettype none
`timescale 1ns/1ps

module tb_multicore;

	localparam int NUM_CORES = 4;
	localparam int STAGGER = 14;
	localparam int TAPS = 4;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	num_pkg::sample_t     in_sample;
	logic [NUM_CORES-1:0] core_req;
	logic                 out_ready;
	logic                 out_valid;
	bus_pkg::out_word_t   out_word;

	// reference model
	int                   since;
	logic [NUM_CORES-1:0] pend;
	logic [NUM_CORES-1:0] exp_req;
	logic                 exp_valid;
	bus_pkg::out_word_t   exp_word;
	num_pkg::sample_t     tap_buf [NUM_CORES][TAPS];
	int                   tap_cnt [NUM_CORES];
	num_pkg::acc_t        held [NUM_CORES];
	int                   round_cnt [NUM_CORES];
	int                   out_cnt [NUM_CORES];
	int                   phase_base [NUM_CORES];

	int                   warm;
	logic                 armed;
	logic [15:0]          lfsr_state;
	string                test_name;
	int                   errors;
	int                   test_errors;
	int                   tests_run;

	tb_clock #(
		.PERIOD_NS(100)
	) u_clock (
		.clk(clk)
	);

	multicore #(
		.NUM_CORES(NUM_CORES),
		.STAGGER  (STAGGER),
		.TAPS     (TAPS)
	) u_multicore (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_sample(in_sample),
		.core_req (core_req),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_word (out_word)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hb400;
		end
		return n;
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	function automatic num_pkg::acc_t expected_sum(input int core);
		int total;
		total = 0;
		for (int t = 0; t < TAPS; t++) begin
			total = total + int'(tap_buf[core][t]) * (core + 1);
		end
		return num_pkg::acc_t'(total);
	endfunction

	function automatic int lowest_index(input logic [NUM_CORES-1:0] mask);
		for (int k = 0; k < NUM_CORES; k++) begin
			if (mask[k]) begin
				return k;
			end
		end
		return 0;
	endfunction

	function automatic logic each_core_gained(input int need);
		logic all_met;
		all_met = 1'b1;
		for (int k = 0; k < NUM_CORES; k++) begin
			if (out_cnt[k] - phase_base[k] < need) begin
				all_met = 1'b0;
			end
		end
		return all_met;
	endfunction

	always @(posedge clk) begin
		if (warm < 2) begin
			warm <= warm + 1;
		end
	end

	// first two edges see the DUT before its registers are reset
	assign armed = (warm >= 2);

	// req is expected k*STAGGER+2 edges after rst_n is seen high, unless a result waits
	always_comb begin
		for (int k = 0; k < NUM_CORES; k++) begin
			exp_req[k] = (since > k * STAGGER + 2) && !pend[k];
		end
	end

	always @(posedge clk) begin : model
		logic [NUM_CORES-1:0] set_mask;
		logic [NUM_CORES-1:0] clr_mask;
		int win;
		set_mask = '0;
		clr_mask = '0;
		if (!rst_n) begin
			since <= 0;
			pend <= '0;
			exp_valid <= 1'b0;
			for (int k = 0; k < NUM_CORES; k++) begin
				tap_cnt[k] = 0;
			end
		end else begin
			since <= since + 1;
			exp_valid <= 1'b0;
			// lowest waiting core wins, only while the sink is ready
			if (out_ready && pend != '0) begin
				win = lowest_index(pend);
				clr_mask[win] = 1'b1;
				exp_valid <= 1'b1;
				exp_word.core_id <= bus_pkg::core_id_t'(win);
				exp_word.data <= held[win];
			end
			for (int k = 0; k < NUM_CORES; k++) begin
				if (out_valid && out_word.core_id == bus_pkg::core_id_t'(k)) begin
					out_cnt[k] <= out_cnt[k] + 1;
				end
				if (in_valid && core_req[k]) begin
					tap_buf[k][tap_cnt[k]] = in_sample;
					if (tap_cnt[k] == TAPS - 1) begin
						held[k] = expected_sum(k);
						set_mask[k] = 1'b1;
						round_cnt[k] <= round_cnt[k] + 1;
						tap_cnt[k] = 0;
					end else begin
						tap_cnt[k] = tap_cnt[k] + 1;
					end
				end
			end
			pend <= (pend & ~clr_mask) | set_mask;
		end
	end

	assert property (@(posedge clk) armed |-> (core_req == exp_req))
	else begin
		errors++;
		$display("Mismatch %s core_req: expected %b actual %b",
			test_name, $sampled(exp_req), $sampled(core_req));
	end

	assert property (@(posedge clk) armed |-> ((pend & core_req) == '0))
	else begin
		errors++;
		$display("%s: a core with a waiting result still asks for samples (req %b)",
			test_name, $sampled(core_req));
	end

	assert property (@(posedge clk) armed && out_valid |-> $past(out_ready))
	else begin
		errors++;
		$display("%s: out_valid rose although out_ready was low one edge before", test_name);
	end

	assert property (@(posedge clk) armed |-> (out_valid == exp_valid))
	else begin
		errors++;
		$display("Mismatch %s out_valid: expected %0d actual %0d",
			test_name, $sampled(exp_valid), $sampled(out_valid));
	end

	assert property (@(posedge clk)
		armed && out_valid && exp_valid |-> (out_word.core_id == exp_word.core_id))
	else begin
		errors++;
		$display("Mismatch %s out_word.core_id: expected %0d actual %0d",
			test_name, $sampled(exp_word.core_id), $sampled(out_word.core_id));
	end

	assert property (@(posedge clk)
		armed && out_valid && exp_valid |-> (out_word.data == exp_word.data))
	else begin
		errors++;
		$display("Mismatch %s out_word.data: expected %0d actual %0d",
			test_name, $sampled(exp_word.data), $sampled(out_word.data));
	end

	task automatic drive_idle();
		@(posedge clk);
		in_valid <= 1'b0;
		out_ready <= 1'b1;
	endtask

	task automatic drive_cycle(input logic ready);
		logic [31:0] r;
		logic [31:0] pick;
		draw_bits(2, r);
		draw_bits(2, pick);
		@(posedge clk);
		in_valid <= (r[1:0] != 2'd0);
		out_ready <= ready;
		if (pick[1:0] == 2'd0) begin
			in_sample <= 16'sh7fff;
		end else if (pick[1:0] == 2'd1) begin
			in_sample <= 16'sh8000;
		end else begin
			draw_bits(16, r);
			in_sample <= num_pkg::sample_t'(r[15:0]);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = errors;
		for (int k = 0; k < NUM_CORES; k++) begin
			phase_base[k] = out_cnt[k];
		end
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %s finished with %0d errors", test_name, errors - test_errors);
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("timeout in %s: %s", test_name, what);
	endtask

	task automatic test_reset(output logic ok);
		int cycles;
		start_test("reset");
		for (int i = 0; i < 2; i++) begin
			@(posedge clk);
		end
		rst_n <= 1'b1;
		out_ready <= 1'b1;
		cycles = 0;
		while (core_req != '1 && cycles < 200) begin
			drive_idle();
			cycles++;
		end
		ok = (core_req == '1);
		if (!ok) begin
			report_timeout("the cores never all raised req after reset");
		end
		end_test();
	endtask

	task automatic test_traffic(output logic ok);
		int cycles;
		logic [31:0] r;
		start_test("traffic");
		cycles = 0;
		while (!each_core_gained(3) && cycles < 3000) begin
			draw_bits(3, r);
			drive_cycle(r[2:0] != 3'd0);
			cycles++;
		end
		ok = each_core_gained(3);
		if (!ok) begin
			report_timeout("not every core delivered three results");
		end
		end_test();
	endtask

	task automatic test_backpressure(output logic ok);
		int cycles;
		int low_len;
		int high_len;
		logic [31:0] r;
		start_test("back_pressure");
		cycles = 0;
		while (!each_core_gained(3) && cycles < 20000) begin
			// long stall, then a short burst with the sink ready
			draw_bits(5, r);
			low_len = 16 + int'(r[4:0]);
			for (int i = 0; i < low_len; i++) begin
				drive_cycle(1'b0);
			end
			draw_bits(2, r);
			high_len = 2 + int'(r[1:0]);
			for (int i = 0; i < high_len; i++) begin
				drive_cycle(1'b1);
			end
			cycles = cycles + low_len + high_len;
		end
		ok = each_core_gained(3);
		if (!ok) begin
			report_timeout("results stopped arriving under back-pressure");
		end
		end_test();
	endtask

	task automatic test_drain(output logic ok);
		int cycles;
		start_test("drain");
		// samples already on the way may still close a round
		for (int i = 0; i < 2; i++) begin
			drive_idle();
		end
		cycles = 0;
		while ((pend != '0 || exp_valid) && cycles < 100) begin
			drive_idle();
			cycles++;
		end
		ok = (pend == '0 && !exp_valid);
		if (!ok) begin
			report_timeout("waiting results were never drained");
		end
		for (int i = 0; i < 4; i++) begin
			drive_idle();
		end
		for (int k = 0; k < NUM_CORES; k++) begin
			assert (out_cnt[k] == round_cnt[k])
			else begin
				errors++;
				$display("Mismatch %s results of core %0d: expected %0d actual %0d",
					test_name, k, round_cnt[k], out_cnt[k]);
			end
		end
		end_test();
	endtask

	task automatic finish_run();
		int results;
		results = 0;
		for (int k = 0; k < NUM_CORES; k++) begin
			results = results + out_cnt[k];
		end
		$display("summary: %0d tests run, %0d results checked, %0d errors",
			tests_run, results, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	initial begin
		logic ok;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_sample = '0;
		out_ready = 1'b0;
		warm = 0;
		lfsr_state = 16'd23640;
		errors = 0;
		tests_run = 0;
		test_reset(ok);
		if (ok) begin
			test_traffic(ok);
		end
		if (ok) begin
			test_backpressure(ok);
		end
		if (ok) begin
			test_drain(ok);
		end
		finish_run();
	end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// free running, first rising edge at half a period
	always begin
		#(PERIOD_NS / 2);
		clk = ~clk;
	end

endmodule

`default_nettype wire

// File: design/multicore.sv
`default_nettype none
`timescale 1ns/1ps

module multicore #(
	parameter int NUM_CORES = bus_pkg::DEF_CORES,
	parameter int STAGGER = 14,
	parameter int TAPS = num_pkg::DEF_TAPS
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  num_pkg::sample_t     in_sample,
	output logic [NUM_CORES-1:0] core_req,
	input  logic                 out_ready,
	output logic                 out_valid,
	output bus_pkg::out_word_t   out_word
);

	logic [NUM_CORES-1:0] core_rst_n;
	logic [NUM_CORES-1:0] res_valid;
	logic [NUM_CORES-1:0] grant;
	bus_pkg::out_word_t   res_word [NUM_CORES];

	// cores leave reset one by one
	rst_stagger #(
		.NUM_CORES(NUM_CORES),
		.STAGGER  (STAGGER)
	) u_rst_stagger (
		.clk       (clk),
		.rst_n     (rst_n),
		.core_rst_n(core_rst_n)
	);

	// every core sees the same sample stream
	for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
		neuron_core #(
			.TAPS   (TAPS),
			.CORE_ID(k)
		) u_core (
			.clk      (clk),
			.rst_n    (core_rst_n[k]),
			.in_valid (in_valid),
			.in_sample(in_sample),
			.req      (core_req[k]),
			.res_valid(res_valid[k]),
			.res_word (res_word[k]),
			.grant    (grant[k])
		);
	end

	out_collector #(
		.NUM_CORES(NUM_CORES)
	) u_out_collector (
		.clk      (clk),
		.rst_n    (rst_n),
		.out_ready(out_ready),
		.res_valid(res_valid),
		.res_word (res_word),
		.grant    (grant),
		.out_valid(out_valid),
		.out_word (out_word)
	);

endmodule

`default_nettype wire

// File: design/out_collector.sv
`default_nettype none
`timescale 1ns/1ps

module out_collector #(
	parameter int NUM_CORES = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 out_ready,
	input  logic [NUM_CORES-1:0] res_valid,
	input  bus_pkg::out_word_t   res_word [NUM_CORES],
	output logic [NUM_CORES-1:0] grant,
	output logic                 out_valid,
	output bus_pkg::out_word_t   out_word
);

	logic [NUM_CORES-1:0] first;
	logic                 any_grant;
	bus_pkg::out_word_t   sel_word;

	// lowest set bit of res_valid, so core 0 has the highest priority
	assign first = res_valid & (~res_valid + 1'b1);

	// nothing leaves a core while the sink is stalled
	assign grant = out_ready ? first : '0;
	assign any_grant = |grant;

	// grant is one-hot, at most one word is picked
	always_comb begin
		sel_word = '0;
		for (int k = 0; k < NUM_CORES; k++) begin
			if (grant[k]) begin
				sel_word = res_word[k];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= any_grant;
		end
	end

	// word is held between transfers
	always_ff @(posedge clk) begin
		if (any_grant) begin
			out_word <= sel_word;
		end
	end

endmodule

`default_nettype wire

// File: design/neuron_core.sv
`default_nettype none
`timescale 1ns/1ps

module neuron_core #(
	parameter int TAPS = 4,
	parameter int CORE_ID = 0
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  num_pkg::sample_t   in_sample,
	output logic               req,
	output logic               res_valid,
	output bus_pkg::out_word_t res_word,
	input  logic               grant
);

	localparam int TAP_W = $clog2(TAPS + 1);
	localparam logic [TAP_W-1:0] TAP_LAST = TAP_W'(TAPS - 1);

	// fixed weight, one more than the core index
	localparam num_pkg::acc_t WEIGHT = num_pkg::acc_t'(CORE_ID + 1);
	localparam bus_pkg::core_id_t MY_ID = bus_pkg::core_id_t'(CORE_ID);

	typedef enum logic {
		S_COLLECT,
		S_HOLD
	} state_t;

	state_t           state;
	logic [TAP_W-1:0] taps;
	num_pkg::acc_t    acc;
	num_pkg::acc_t    acc_next;
	logic             take;
	logic             last;

	// a sample counts only in a cycle where this core asks for it
	assign take = req && in_valid;
	assign last = take && (taps == TAP_LAST);

	assign acc_next = num_pkg::mac(acc, in_sample, WEIGHT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_COLLECT;
			req <= 1'b0;
			taps <= '0;
			acc <= '0;
		end else begin
			case (state)
				S_COLLECT: begin
					if (take) begin
						acc <= acc_next;
						if (last) begin
							// round complete, stop asking and present the sum
							taps <= '0;
							req <= 1'b0;
							state <= S_HOLD;
						end else begin
							taps <= taps + 1'b1;
						end
					end else begin
						// also opens the request on the first cycle after release
						req <= 1'b1;
					end
				end
				S_HOLD: begin
					// sum stays put until the collector takes it
					if (grant) begin
						acc <= '0;
						req <= 1'b1;
						state <= S_COLLECT;
					end
				end
				default: begin
					state <= S_COLLECT;
				end
			endcase
		end
	end

	assign res_valid = (state == S_HOLD);
	assign res_word = bus_pkg::make_word(MY_ID, acc);

endmodule

`default_nettype wire

// File: design/rst_stagger.sv
`default_nettype none
`timescale 1ns/1ps

module rst_stagger #(
	parameter int NUM_CORES = 4,
	parameter int STAGGER = 14
) (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic [NUM_CORES-1:0] core_rst_n
);

	localparam int CNT_W = $clog2(STAGGER + 1);
	localparam int IDX_W = $clog2(NUM_CORES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STAGGER);
	localparam logic [IDX_W-1:0] IDX_DONE = IDX_W'(NUM_CORES);

	logic [CNT_W-1:0] cnt;
	logic [IDX_W-1:0] idx;
	logic             done;
	logic             fire;

	// idx walks past the last core and then parks there
	assign done = (idx == IDX_DONE);
	assign fire = !done && (cnt == CNT_LAST);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// preloaded so core 0 is let go one edge after rst_n is seen high
			cnt <= CNT_LAST - 1'b1;
			idx <= '0;
		end else if (!done) begin
			if (fire) begin
				cnt <= CNT_W'(1);
				idx <= idx + 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// per-core release bits, set once and held until rst_n drops
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			core_rst_n <= '0;
		end else if (fire) begin
			for (int k = 0; k < NUM_CORES; k++) begin
				if (idx == IDX_W'(k)) begin
					core_rst_n[k] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// 5 bits covers the largest array of 32 cores
	localparam int CORE_ID_W = 5;

	// cores built unless the top level says otherwise
	localparam int DEF_CORES = 4;

	typedef logic [CORE_ID_W-1:0] core_id_t;

	// result word from a core, tagged with its origin
	typedef struct packed {
		core_id_t      core_id;
		num_pkg::acc_t data;
	} out_word_t;

	function automatic out_word_t make_word(
		input core_id_t      core_id,
		input num_pkg::acc_t data
	);
		out_word_t w;
		w.core_id = core_id;
		w.data = data;
		return w;
	endfunction

endpackage

`default_nettype wire

// File: design/num_pkg.sv
`default_nettype none

package num_pkg;

	// sample and accumulator widths
	localparam int SAMPLE_W = 16;
	localparam int ACC_W = 24;

	// samples folded into one result unless the top level says otherwise
	localparam int DEF_TAPS = 4;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// running sum and result, wraps at ACC_W
	typedef logic signed [ACC_W-1:0] acc_t;

	// one multiply-accumulate step at accumulator width
	function automatic acc_t mac(
		input acc_t    acc,
		input sample_t sample,
		input acc_t    weight
	);
		acc_t ext;
		ext = acc_t'(sample);
		return acc + ext * weight;
	endfunction

endpackage

`default_nettype wire
